//--- hdl/ts_consts.svh
`ifndef TS_CONSTS_SVH
`define TS_CONSTS_SVH

// Stream format
`define TS_PACKET_BYTES 188
`define TS_SYNC_BYTE 8'h47

// Packet store geometry
`define TS_DATA_WIDTH 32
`define TS_PACKET_WORDS 47

// Register map
`define REG_PID 12'h000
`define REG_CTRL 12'h004
`define REG_STATUS 12'h008
`define REG_WINDOW 12'h100

`endif

//--- hdl/ts_pkg.sv
`include "ts_consts.svh"

package ts_pkg;

	typedef logic [7:0] ts_byte_t;
	typedef logic [12:0] pid_t;

	// Position of a byte inside a packet, 0 to 187
	typedef logic [7:0] byte_idx_t;

	// Position of a word inside a bank, 0 to 46
	typedef logic [5:0] word_idx_t;

	typedef logic [`TS_DATA_WIDTH-1:0] pkt_word_t;

	typedef enum logic {
		HUNT,
		CAPTURE
	} cap_state_e;

endpackage

//--- hdl/axil_pkg.sv
package axil_pkg;

	typedef logic [11:0] axil_addr_t;
	typedef logic [31:0] axil_data_t;
	typedef logic [3:0] axil_strb_t;
	typedef logic [1:0] axil_resp_t;

	localparam axil_resp_t OKAY = 2'b00;
	localparam axil_resp_t SLVERR = 2'b10;

endpackage

//--- hdl/ts_buf_if.sv
interface ts_buf_if;

	logic wr_en;
	ts_pkg::byte_idx_t wr_byte;
	ts_pkg::ts_byte_t wr_data;
	logic commit; // With the write of the last byte

	logic hold; // Freeze the readable bank
	ts_pkg::word_idx_t rd_addr;
	logic rd_en;

	ts_pkg::pkt_word_t rd_data;
	logic [15:0] pkt_count;

	modport capture (
		output wr_en,
		output wr_byte,
		output wr_data,
		output commit
	);

	modport buffer (
		input wr_en,
		input wr_byte,
		input wr_data,
		input commit,
		input hold,
		input rd_addr,
		input rd_en,
		output rd_data,
		output pkt_count
	);

	modport host (
		output hold,
		output rd_addr,
		output rd_en,
		input rd_data,
		input pkt_count
	);

endinterface

//--- hdl/ts_pid_capture.sv
`include "ts_consts.svh"

module ts_pid_capture (
	input logic mpeg_clk,
	input logic S_AXI_ARESETN,
	input ts_pkg::ts_byte_t mpeg_data,
	input logic mpeg_valid,
	input logic mpeg_sync,
	input ts_pkg::pid_t pid,
	input logic enable,
	ts_buf_if.capture buf_port
);

	ts_pkg::ts_byte_t data_d1;
	ts_pkg::ts_byte_t data_d2;
	ts_pkg::ts_byte_t data_d3;
	logic sync_d1;
	logic sync_d2;

	ts_pkg::cap_state_e state;
	ts_pkg::byte_idx_t byte_idx;
	logic hdr_hit;
	logic last_byte;

	// Look-ahead moves only on valid beats
	always_ff @(posedge mpeg_clk) begin
		if (mpeg_valid) begin
			data_d1 <= mpeg_data;
			data_d2 <= data_d1;
			data_d3 <= data_d2;
		end
	end

	always_ff @(posedge mpeg_clk) begin
		if (!S_AXI_ARESETN) begin
			sync_d1 <= 1'b0;
			sync_d2 <= 1'b0;
		end else if (mpeg_valid) begin
			sync_d1 <= mpeg_sync;
			sync_d2 <= sync_d1;
		end
	end

	// Byte 0 in stage 2, byte 1 in stage 1, byte 2 on the input
	assign hdr_hit = mpeg_valid && sync_d2 && (data_d2 == `TS_SYNC_BYTE) &&
		({data_d1[4:0], mpeg_data} == pid);

	assign last_byte = (byte_idx == ts_pkg::byte_idx_t'(`TS_PACKET_BYTES - 1));

	assign buf_port.wr_en = (state == ts_pkg::CAPTURE) && mpeg_valid;
	assign buf_port.wr_byte = byte_idx;
	assign buf_port.wr_data = data_d3; // Three beats behind the input
	assign buf_port.commit = buf_port.wr_en && last_byte;

	always_ff @(posedge mpeg_clk) begin
		if (!S_AXI_ARESETN) begin
			state <= ts_pkg::HUNT;
			byte_idx <= '0;
		end else if (!enable) begin
			state <= ts_pkg::HUNT;
		end else if (mpeg_valid) begin
			if (sync_d2) begin
				// A sync here ends any packet in progress; the last byte still commits
				if (hdr_hit) begin
					state <= ts_pkg::CAPTURE;
					byte_idx <= '0;
				end else begin
					state <= ts_pkg::HUNT;
				end
			end else if (state == ts_pkg::CAPTURE) begin
				if (last_byte) begin
					state <= ts_pkg::HUNT;
				end
				byte_idx <= byte_idx + 8'd1;
			end
		end
	end

endmodule

//--- hdl/ts_packet_buffer.sv
`include "ts_consts.svh"

module ts_packet_buffer (
	input logic mpeg_clk,
	input logic S_AXI_ARESETN,
	ts_buf_if.buffer buf_port
);

	ts_pkg::pkt_word_t bank_mem [0:1][0:`TS_PACKET_WORDS-1];
	logic front; // Bank visible to the host
	ts_pkg::word_idx_t wr_word;
	logic [1:0] wr_lane;

	assign wr_word = buf_port.wr_byte[7:2];
	assign wr_lane = buf_port.wr_byte[1:0];

	// Little-endian lanes, always into the back bank
	always_ff @(posedge mpeg_clk) begin
		if (buf_port.wr_en) begin
			bank_mem[~front][wr_word][{wr_lane, 3'b000} +: 8] <= buf_port.wr_data;
		end
	end

	always_ff @(posedge mpeg_clk) begin
		if (buf_port.rd_en) begin
			buf_port.rd_data <= bank_mem[front][buf_port.rd_addr];
		end
	end

	always_ff @(posedge mpeg_clk) begin
		if (!S_AXI_ARESETN) begin
			front <= 1'b0;
			buf_port.pkt_count <= '0;
		end else if (buf_port.commit) begin
			buf_port.pkt_count <= buf_port.pkt_count + 16'd1;
			if (!buf_port.hold) begin
				front <= ~front; // Completed packet becomes readable
			end
		end
	end

endmodule

//--- hdl/axil_monitor_regs.sv
`include "ts_consts.svh"

module axil_monitor_regs (
	input logic mpeg_clk,
	input logic S_AXI_ARESETN,
	input axil_pkg::axil_addr_t s_axi_awaddr,
	input logic s_axi_awvalid,
	output logic s_axi_awready,
	input axil_pkg::axil_data_t s_axi_wdata,
	input axil_pkg::axil_strb_t s_axi_wstrb,
	input logic s_axi_wvalid,
	output logic s_axi_wready,
	output axil_pkg::axil_resp_t s_axi_bresp,
	output logic s_axi_bvalid,
	input logic s_axi_bready,
	input axil_pkg::axil_addr_t s_axi_araddr,
	input logic s_axi_arvalid,
	output logic s_axi_arready,
	output axil_pkg::axil_data_t s_axi_rdata,
	output axil_pkg::axil_resp_t s_axi_rresp,
	output logic s_axi_rvalid,
	input logic s_axi_rready,
	output ts_pkg::pid_t pid,
	output logic enable,
	ts_buf_if.host buf_port
);

	logic [1:0] ctrl; // Bit 0 enable, bit 1 hold
	logic rd_busy;
	logic rd_pend;
	logic rd_win;
	logic win_hit;
	axil_pkg::axil_addr_t win_off;
	axil_pkg::axil_addr_t ar_addr_q;
	axil_pkg::axil_data_t rdata_q;

	assign enable = ctrl[0];
	assign buf_port.hold = ctrl[1];
	assign s_axi_wready = s_axi_awready;

	// Write channel
	always_ff @(posedge mpeg_clk) begin
		if (!S_AXI_ARESETN) begin
			s_axi_awready <= 1'b0;
			s_axi_bvalid <= 1'b0;
			s_axi_bresp <= axil_pkg::OKAY;
			pid <= '0;
			ctrl <= '0;
		end else begin
			s_axi_awready <= s_axi_awvalid && s_axi_wvalid && !s_axi_awready && !s_axi_bvalid;
			if (s_axi_awready) begin
				s_axi_bvalid <= 1'b1;
				s_axi_bresp <= axil_pkg::OKAY;
				case (s_axi_awaddr)
					`REG_PID: begin
						if (s_axi_wstrb[0]) begin
							pid[7:0] <= s_axi_wdata[7:0];
						end
						if (s_axi_wstrb[1]) begin
							pid[12:8] <= s_axi_wdata[12:8];
						end
					end
					`REG_CTRL: begin
						if (s_axi_wstrb[0]) begin
							ctrl <= s_axi_wdata[1:0];
						end
					end
					default: s_axi_bresp <= axil_pkg::SLVERR; // STATUS, window, unmapped
				endcase
			end else if (s_axi_bready) begin
				s_axi_bvalid <= 1'b0;
			end
		end
	end

	assign win_off = s_axi_araddr - `REG_WINDOW;
	assign win_hit = (s_axi_araddr >= `REG_WINDOW) &&
		(win_off[11:2] < 10'(`TS_PACKET_WORDS));

	// Read channel, buffer word arrives one cycle after rd_en
	always_ff @(posedge mpeg_clk) begin
		if (!S_AXI_ARESETN) begin
			s_axi_arready <= 1'b0;
			s_axi_rvalid <= 1'b0;
			s_axi_rresp <= axil_pkg::OKAY;
			rd_busy <= 1'b0;
			rd_pend <= 1'b0;
			rd_win <= 1'b0;
			buf_port.rd_en <= 1'b0;
		end else begin
			s_axi_arready <= s_axi_arvalid && !rd_busy && !s_axi_arready;
			buf_port.rd_en <= 1'b0;
			rd_pend <= 1'b0;
			if (s_axi_arready) begin
				rd_busy <= 1'b1;
				rd_pend <= 1'b1;
				rd_win <= win_hit;
				buf_port.rd_en <= win_hit;
			end
			if (rd_pend) begin
				s_axi_rvalid <= 1'b1;
				case (ar_addr_q)
					`REG_PID, `REG_CTRL, `REG_STATUS: s_axi_rresp <= axil_pkg::OKAY;
					default: s_axi_rresp <= rd_win ? axil_pkg::OKAY : axil_pkg::SLVERR;
				endcase
			end else if (s_axi_rvalid && s_axi_rready) begin
				s_axi_rvalid <= 1'b0;
				rd_busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge mpeg_clk) begin
		if (s_axi_arready) begin
			ar_addr_q <= s_axi_araddr;
			buf_port.rd_addr <= win_off[7:2];
		end
		if (rd_pend) begin
			case (ar_addr_q)
				`REG_PID: rdata_q <= {19'd0, pid};
				`REG_CTRL: rdata_q <= {30'd0, ctrl};
				`REG_STATUS: rdata_q <= {16'd0, buf_port.pkt_count};
				default: rdata_q <= '0;
			endcase
		end
	end

	assign s_axi_rdata = rd_win ? buf_port.rd_data : rdata_q;

endmodule

//--- hdl/ts_monitor_top.sv
module ts_monitor_top (
	input logic mpeg_clk,
	input logic S_AXI_ARESETN,
	input ts_pkg::ts_byte_t mpeg_data,
	input logic mpeg_valid,
	input logic mpeg_sync,
	input axil_pkg::axil_addr_t s_axi_awaddr,
	input logic s_axi_awvalid,
	output logic s_axi_awready,
	input axil_pkg::axil_data_t s_axi_wdata,
	input axil_pkg::axil_strb_t s_axi_wstrb,
	input logic s_axi_wvalid,
	output logic s_axi_wready,
	output axil_pkg::axil_resp_t s_axi_bresp,
	output logic s_axi_bvalid,
	input logic s_axi_bready,
	input axil_pkg::axil_addr_t s_axi_araddr,
	input logic s_axi_arvalid,
	output logic s_axi_arready,
	output axil_pkg::axil_data_t s_axi_rdata,
	output axil_pkg::axil_resp_t s_axi_rresp,
	output logic s_axi_rvalid,
	input logic s_axi_rready
);

	ts_buf_if buf_if ();
	ts_pkg::pid_t pid;
	logic enable;

	ts_pid_capture u_capture (
		.mpeg_clk(mpeg_clk),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.mpeg_data(mpeg_data),
		.mpeg_valid(mpeg_valid),
		.mpeg_sync(mpeg_sync),
		.pid(pid),
		.enable(enable),
		.buf_port(buf_if.capture)
	);

	ts_packet_buffer u_buffer (
		.mpeg_clk(mpeg_clk),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.buf_port(buf_if.buffer)
	);

	axil_monitor_regs u_regs (
		.mpeg_clk(mpeg_clk),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.s_axi_awaddr(s_axi_awaddr),
		.s_axi_awvalid(s_axi_awvalid),
		.s_axi_awready(s_axi_awready),
		.s_axi_wdata(s_axi_wdata),
		.s_axi_wstrb(s_axi_wstrb),
		.s_axi_wvalid(s_axi_wvalid),
		.s_axi_wready(s_axi_wready),
		.s_axi_bresp(s_axi_bresp),
		.s_axi_bvalid(s_axi_bvalid),
		.s_axi_bready(s_axi_bready),
		.s_axi_araddr(s_axi_araddr),
		.s_axi_arvalid(s_axi_arvalid),
		.s_axi_arready(s_axi_arready),
		.s_axi_rdata(s_axi_rdata),
		.s_axi_rresp(s_axi_rresp),
		.s_axi_rvalid(s_axi_rvalid),
		.s_axi_rready(s_axi_rready),
		.pid(pid),
		.enable(enable),
		.buf_port(buf_if.host)
	);

endmodule

//--- tests/tb_ts_monitor.sv
`include "ts_consts.svh"

module tb_ts_monitor;

	typedef struct packed {
		ts_pkg::pid_t pkt_pid;
		logic good_sync; // First byte is 0x47
		logic truncated;
		logic hold;
		ts_pkg::pid_t reg_pid;
	} stim_row_t;

	localparam int NUM_ROWS = 8;
	localparam int TIMEOUT_CYCLES = NUM_ROWS * 260 + 2000;

	localparam stim_row_t STIM [0:NUM_ROWS-1] = '{
		'{13'h0100, 1'b1, 1'b0, 1'b0, 13'h0100},
		'{13'h00ab, 1'b1, 1'b0, 1'b0, 13'h0100}, // Other PID
		'{13'h1100, 1'b1, 1'b0, 1'b0, 13'h0100}, // Differs in top bit only
		'{13'h0100, 1'b0, 1'b0, 1'b0, 13'h0100}, // Bad first byte
		'{13'h0100, 1'b1, 1'b1, 1'b0, 13'h0100}, // Cut short
		'{13'h1fff, 1'b1, 1'b0, 1'b1, 13'h1fff}, // Front bank frozen
		'{13'h1fff, 1'b1, 1'b0, 1'b0, 13'h1fff},
		'{13'h0a5a, 1'b1, 1'b0, 1'b0, 13'h0a5a}
	};

	logic mpeg_clk;
	logic S_AXI_ARESETN;
	ts_pkg::ts_byte_t mpeg_data;
	logic mpeg_valid;
	logic mpeg_sync;
	axil_pkg::axil_addr_t s_axi_awaddr;
	logic s_axi_awvalid;
	logic s_axi_awready;
	axil_pkg::axil_data_t s_axi_wdata;
	axil_pkg::axil_strb_t s_axi_wstrb;
	logic s_axi_wvalid;
	logic s_axi_wready;
	axil_pkg::axil_resp_t s_axi_bresp;
	logic s_axi_bvalid;
	logic s_axi_bready;
	axil_pkg::axil_addr_t s_axi_araddr;
	logic s_axi_arvalid;
	logic s_axi_arready;
	axil_pkg::axil_data_t s_axi_rdata;
	axil_pkg::axil_resp_t s_axi_rresp;
	logic s_axi_rvalid;
	logic s_axi_rready;

	int data_errors = 0;
	int resp_errors = 0;
	int proto_errors = 0;
	int cycle_count = 0;
	int seed_val;
	logic [15:0] exp_count;
	logic front_valid;
	ts_pkg::ts_byte_t cur_pkt [0:`TS_PACKET_BYTES-1];
	ts_pkg::ts_byte_t front_pkt [0:`TS_PACKET_BYTES-1]; // Packet the host should see

	ts_monitor_top UUT (.*);

	initial begin
		mpeg_clk = 1'b0;
		forever #2 mpeg_clk = ~mpeg_clk;
	end

	always @(posedge mpeg_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
			$display("Test FAILED");
			$finish;
		end
	end

	task automatic check_data(input axil_pkg::axil_data_t got, input axil_pkg::axil_data_t exp_val,
		input string what);
		if (got !== exp_val) begin
			$display("[ERROR] %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp_val);
			data_errors++;
		end
	endtask

	task automatic check_resp(input axil_pkg::axil_resp_t got, input axil_pkg::axil_resp_t exp_val,
		input string what);
		if (got !== exp_val) begin
			$display("[ERROR] %0t: %s response is %0d, expected %0d", $time, what, got, exp_val);
			resp_errors++;
		end
	endtask

	// Called right after a falling edge, returns on one
	task automatic axi_write(input axil_pkg::axil_addr_t addr, input axil_pkg::axil_data_t data,
		input axil_pkg::axil_strb_t strb, output axil_pkg::axil_resp_t resp);
		int stall;
		stall = $urandom_range(3, 0);
		s_axi_awaddr = addr;
		s_axi_wdata = data;
		s_axi_wstrb = strb;
		s_axi_awvalid = 1'b1;
		s_axi_wvalid = 1'b1;
		@(negedge mpeg_clk);
		while (!s_axi_awready) @(negedge mpeg_clk);
		if (!s_axi_wready) begin
			$display("WREADY low at %0t while AWREADY was high", $time);
			proto_errors++;
		end
		@(negedge mpeg_clk);
		s_axi_awvalid = 1'b0;
		s_axi_wvalid = 1'b0;
		while (!s_axi_bvalid) @(negedge mpeg_clk);
		repeat (stall) begin // BREADY low
			@(negedge mpeg_clk);
			if (!s_axi_bvalid) begin
				$display("BVALID dropped at %0t while BREADY was low", $time);
				proto_errors++;
			end
		end
		resp = s_axi_bresp;
		s_axi_bready = 1'b1;
		@(negedge mpeg_clk);
		s_axi_bready = 1'b0;
	endtask

	task automatic axi_read(input axil_pkg::axil_addr_t addr, output axil_pkg::axil_data_t data,
		output axil_pkg::axil_resp_t resp);
		int stall;
		stall = $urandom_range(3, 0);
		s_axi_araddr = addr;
		s_axi_arvalid = 1'b1;
		@(negedge mpeg_clk);
		while (!s_axi_arready) @(negedge mpeg_clk);
		@(negedge mpeg_clk);
		s_axi_arvalid = 1'b0;
		while (!s_axi_rvalid) @(negedge mpeg_clk);
		data = s_axi_rdata;
		resp = s_axi_rresp;
		repeat (stall) begin // RDATA must hold while RREADY is low
			@(negedge mpeg_clk);
			if (!s_axi_rvalid) begin
				$display("RVALID dropped at %0t while RREADY was low", $time);
				proto_errors++;
			end
			check_data(s_axi_rdata, data, "RDATA during stall");
			check_resp(s_axi_rresp, resp, "RRESP during stall");
		end
		s_axi_rready = 1'b1;
		@(negedge mpeg_clk);
		s_axi_rready = 1'b0;
	endtask

	task automatic send_byte(input ts_pkg::ts_byte_t data, input logic sync);
		if ($urandom_range(15, 0) == 0) begin
			mpeg_valid = 1'b0;
			repeat ($urandom_range(2, 1)) @(negedge mpeg_clk); // Idle gap
		end
		mpeg_data = data;
		mpeg_sync = sync;
		mpeg_valid = 1'b1;
		@(negedge mpeg_clk);
		mpeg_valid = 1'b0;
		mpeg_sync = 1'b0;
	endtask

	task automatic send_packet(input stim_row_t row);
		int len;
		len = row.truncated ? int'($urandom_range(150, 20)) : `TS_PACKET_BYTES;
		for (int k = 0; k < `TS_PACKET_BYTES; k++) begin
			cur_pkt[k] = ts_pkg::ts_byte_t'($urandom);
		end
		cur_pkt[0] = row.good_sync ? `TS_SYNC_BYTE : 8'hb8;
		cur_pkt[1] = {cur_pkt[1][7:5], row.pkt_pid[12:8]};
		cur_pkt[2] = row.pkt_pid[7:0];
		for (int k = 0; k < len; k++) begin
			send_byte(cur_pkt[k], k == 0);
		end
		// Sync-marked filler ends the packet and flushes the look-ahead
		send_byte(8'h00, 1'b1);
		send_byte(8'h00, 1'b0);
		send_byte(8'h00, 1'b0);
	endtask

	task automatic check_window(input logic full);
		axil_pkg::axil_data_t got;
		axil_pkg::axil_data_t exp_word;
		axil_pkg::axil_resp_t resp;
		for (int i = 0; i < `TS_PACKET_WORDS; i++) begin
			if (full || i == 0 || i == 23 || i == `TS_PACKET_WORDS - 1) begin
				exp_word = {front_pkt[4*i+3], front_pkt[4*i+2], front_pkt[4*i+1], front_pkt[4*i]};
				axi_read(`REG_WINDOW + axil_pkg::axil_addr_t'(4 * i), got, resp);
				check_data(got, exp_word, $sformatf("window word %0d", i));
				check_resp(resp, axil_pkg::OKAY, "window read");
			end
		end
	endtask

	initial begin
		axil_pkg::axil_data_t rd;
		axil_pkg::axil_resp_t resp;
		logic match;
		seed_val = $urandom(32'h1f313611);
		S_AXI_ARESETN = 1'b0;
		mpeg_data = '0;
		mpeg_valid = 1'b0;
		mpeg_sync = 1'b0;
		s_axi_awaddr = '0;
		s_axi_awvalid = 1'b0;
		s_axi_wdata = '0;
		s_axi_wstrb = '0;
		s_axi_wvalid = 1'b0;
		s_axi_bready = 1'b0;
		s_axi_araddr = '0;
		s_axi_arvalid = 1'b0;
		s_axi_rready = 1'b0;
		exp_count = '0;
		front_valid = 1'b0;
		repeat (16) @(negedge mpeg_clk);
		S_AXI_ARESETN = 1'b1;
		@(negedge mpeg_clk);

		axi_write(`REG_PID, 32'hffff_ffff, 4'hf, resp);
		check_resp(resp, axil_pkg::OKAY, "PID write");
		axi_read(`REG_PID, rd, resp);
		check_data(rd, 32'h0000_1fff, "PID after full write");
		axi_write(`REG_PID, 32'h0000_00ab, 4'h1, resp); // Low lane only
		axi_read(`REG_PID, rd, resp);
		check_data(rd, 32'h0000_1fab, "PID after lane 0 write");
		axi_write(`REG_CTRL, 32'hffff_ffff, 4'hf, resp);
		axi_read(`REG_CTRL, rd, resp);
		check_data(rd, 32'h0000_0003, "CTRL after full write");
		axi_write(`REG_CTRL, 32'h0, 4'hf, resp);
		axi_write(`REG_STATUS, 32'h1234, 4'hf, resp);
		check_resp(resp, axil_pkg::SLVERR, "STATUS write");
		axi_read(`REG_STATUS, rd, resp);
		check_data(rd, 32'h0, "STATUS after reset");
		check_resp(resp, axil_pkg::OKAY, "STATUS read");
		axi_read(12'h00c, rd, resp);
		check_resp(resp, axil_pkg::SLVERR, "unmapped read");

		for (int r = 0; r < NUM_ROWS; r++) begin
			axi_write(`REG_PID, {19'd0, STIM[r].reg_pid}, 4'hf, resp);
			check_resp(resp, axil_pkg::OKAY, "PID write");
			axi_read(`REG_PID, rd, resp);
			check_data(rd, {19'd0, STIM[r].reg_pid}, "PID readback");
			axi_write(`REG_CTRL, {30'd0, STIM[r].hold, 1'b1}, 4'hf, resp);
			check_resp(resp, axil_pkg::OKAY, "CTRL write");
			send_packet(STIM[r]);
			match = (STIM[r].pkt_pid == STIM[r].reg_pid) && STIM[r].good_sync &&
				!STIM[r].truncated;
			if (match) begin
				exp_count = exp_count + 16'd1;
				if (!STIM[r].hold) begin
					front_pkt = cur_pkt;
					front_valid = 1'b1;
				end
			end
			axi_read(`REG_STATUS, rd, resp);
			check_data(rd, {16'd0, exp_count}, $sformatf("STATUS after row %0d", r));
			if (front_valid) begin
				check_window(match);
			end
		end

		$display("Errors: data %0d, response %0d, protocol %0d",
			data_errors, resp_errors, proto_errors);
		if (data_errors + resp_errors + proto_errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

//--- src.f
+incdir+hdl
hdl/ts_pkg.sv
hdl/axil_pkg.sv
hdl/ts_buf_if.sv
hdl/ts_pid_capture.sv
hdl/ts_packet_buffer.sv
hdl/axil_monitor_regs.sv
hdl/ts_monitor_top.sv
tests/tb_ts_monitor.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -j 0 \
	-f src.f \
	--top-module tb_ts_monitor \
	-Mdir "$OBJ" \
	-o tb_ts_monitor
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$OBJ/tb_ts_monitor" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Test OK" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1
